// ==== bench/i2c_init_checker.sv ====
// concurrent checks on the strobes toward the I2C master, bound into i2c_init
// all properties are off while rst is high
`timescale 1ns/100ps
`default_nettype none

module i2c_init_checker (
    input wire       clk,
    input wire       rst,
    input wire       cmd_ready,
    input wire       data_out_ready,
    input wire [6:0] cmd_address,
    input wire       cmd_start,
    input wire       cmd_write,
    input wire       cmd_stop,
    input wire       cmd_valid,
    input wire [7:0] data_out,
    input wire       data_out_valid
);

    // failed assertions so far, read from the testbench
    int unsigned assert_errors = 0;

    // stalled command keeps valid and every field
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_address) &&
            $stable(cmd_start) && $stable(cmd_write) && $stable(cmd_stop))
    else begin
        $error("command changed while the master stalled");
        assert_errors = assert_errors + 1;
    end

    // stalled data byte
    data_hold: assert property (@(posedge clk) disable iff (rst)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
    else begin
        $error("data byte changed while the master stalled");
        assert_errors = assert_errors + 1;
    end

    write_or_stop: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> !(cmd_write && cmd_stop))
    else begin
        $error("write and stop set on one command");
        assert_errors = assert_errors + 1;
    end

    // a data byte only comes with its write command
    data_with_cmd: assert property (@(posedge clk) disable iff (rst)
        $rose(data_out_valid) |-> cmd_valid && cmd_write)
    else begin
        $error("data valid rose without a write command");
        assert_errors = assert_errors + 1;
    end

endmodule

`default_nettype wire

// ==== bench/tb_i2c_init.sv ====
// testbench for the I2C init sequencer, the master is just the two ready inputs
// expected stream follows the table rules: 5 groups of 6 writes, then a stop
// back-pressure test draws both readys from an LCG
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_init;

    // roughly ten times the slowest back-pressured run
    localparam int max_cycles = 4000;
    localparam int num_cmds = 31;
    localparam int num_writes = 30;
    // reg 0x0004 <= 0x11223344
    localparam logic [7:0] wr_bytes [6] = '{8'h00, 8'h04, 8'h11, 8'h22, 8'h33, 8'h44};

    logic clk;
    logic rst;
    logic start;
    logic cmd_ready = 1'b1;
    logic data_out_ready = 1'b1;
    logic [6:0] cmd_address;
    logic cmd_start;
    logic cmd_write;
    logic cmd_stop;
    logic cmd_valid;
    logic [7:0] data_out;
    logic data_out_valid;
    logic busy;

    // accepted commands as {start, write, stop, address}
    logic [9:0] got_cmds [$];
    logic [7:0] got_bytes [$];
    logic random_ready = 1'b0;
    logic [31:0] rng_state = 32'h7417b4b3;
    int cycle_count = 0;
    int busy_cycles = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    i2c_init UUT (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .cmd_ready      (cmd_ready),
        .data_out_ready (data_out_ready),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy)
    );

    bind i2c_init i2c_init_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .cmd_ready      (cmd_ready),
        .data_out_ready (data_out_ready),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // i-th accepted command of one run
    function automatic logic [9:0] exp_cmd(input int i);
        logic [6:0] dev;
        if (i >= num_writes) begin
            // stop leaves the last address in place
            return {3'b001, 7'h53};
        end
        dev = (i < 6) ? 7'h50 : 7'h50 + 7'((i - 6) / 6);
        return {((i % 6) == 0), 2'b10, dev};
    endfunction

    function automatic int total_errors();
        return errors + int'(UUT.u_checker.assert_errors);
    endfunction

    // readys change only on the falling edge
    always @(negedge clk) begin
        if (random_ready) begin
            rng_state = lcg_next(rng_state);
            cmd_ready <= rng_state[16];
            rng_state = lcg_next(rng_state);
            data_out_ready <= rng_state[16];
        end else begin
            cmd_ready <= 1'b1;
            data_out_ready <= 1'b1;
        end
    end

    // scoreboard capture, one entry per handshake
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (busy) begin
            busy_cycles <= busy_cycles + 1;
        end
        if (!rst && cmd_valid && cmd_ready) begin
            got_cmds.push_back({cmd_start, cmd_write, cmd_stop, cmd_address});
        end
        if (!rst && data_out_valid && data_out_ready) begin
            got_bytes.push_back(data_out);
        end
    end

    always @(posedge clk) begin
        if (cycle_count >= max_cycles) begin
            $display("timeout: tests not finished after %0d cycles", max_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_eq(input string test, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string test, input int mark);
        tests_run++;
        if (total_errors() == mark) begin
            $display("test %s: ok", test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test, total_errors() - mark);
        end
    endtask

    // drop start, raise it, wait for the final stop
    task automatic run_once(input logic use_random, input int cmd_base);
        @(posedge clk);
        random_ready = use_random;
        @(negedge clk);
        start = 1'b0;
        repeat (2) @(negedge clk);
        start = 1'b1;
        while (got_cmds.size() <= cmd_base || !got_cmds[got_cmds.size() - 1][7]) begin
            @(negedge clk);
        end
        @(posedge clk);
        random_ready = 1'b0;
        @(negedge clk);
    endtask

    // kind and address of each command, and every data byte
    task automatic check_sequence(input string test, input int cmd_base, input int byte_base);
        logic [9:0] exp;
        check_eq(test, "command count", num_cmds, 32'(got_cmds.size() - cmd_base));
        check_eq(test, "byte count", num_writes, 32'(got_bytes.size() - byte_base));
        for (int i = 0; i < num_cmds && cmd_base + i < got_cmds.size(); i++) begin
            exp = exp_cmd(i);
            check_eq(test, $sformatf("command %0d", i), 32'(exp[8:0]),
                     32'(got_cmds[cmd_base + i][8:0]));
        end
        for (int i = 0; i < num_writes && byte_base + i < got_bytes.size(); i++) begin
            check_eq(test, $sformatf("byte %0d", i), 32'(wr_bytes[i % 6]),
                     32'(got_bytes[byte_base + i]));
        end
    endtask

    task automatic check_starts(input string test, input int cmd_base);
        int starts;
        logic [9:0] exp;
        starts = 0;
        for (int i = 0; i < num_cmds && cmd_base + i < got_cmds.size(); i++) begin
            exp = exp_cmd(i);
            starts += int'(got_cmds[cmd_base + i][9]);
            check_eq(test, $sformatf("start flag %0d", i), 32'(exp[9]),
                     32'(got_cmds[cmd_base + i][9]));
        end
        // one start per address change
        check_eq(test, "start count", 32'd5, 32'(starts));
    endtask

    initial begin
        int mark;
        int cmd_base;
        int byte_base;
        int busy_base;
        rst = 1'b1;
        start = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        mark = total_errors();
        repeat (20) begin
            @(negedge clk);
            check_eq("reset_idle", "cmd_valid", 32'd0, 32'(cmd_valid));
            check_eq("reset_idle", "data_out_valid", 32'd0, 32'(data_out_valid));
            check_eq("reset_idle", "busy", 32'd0, 32'(busy));
        end
        end_test("reset_idle", mark);

        mark = total_errors();
        cmd_base = got_cmds.size();
        byte_base = got_bytes.size();
        run_once(1'b0, cmd_base);
        check_sequence("full_sequence", cmd_base, byte_base);
        end_test("full_sequence", mark);

        // same run as above
        mark = total_errors();
        check_starts("start_flags", cmd_base);
        end_test("start_flags", mark);

        mark = total_errors();
        cmd_base = got_cmds.size();
        byte_base = got_bytes.size();
        run_once(1'b1, cmd_base);
        check_sequence("back_pressure", cmd_base, byte_base);
        check_starts("back_pressure", cmd_base);
        end_test("back_pressure", mark);

        mark = total_errors();
        busy_base = busy_cycles;
        cmd_base = got_cmds.size();
        run_once(1'b0, cmd_base);
        check_eq("restart", "busy during run", 32'd1, 32'(busy_cycles > busy_base));
        check_eq("restart", "busy after stop", 32'd0, 32'(busy));
        // start still high, no second run
        cmd_base = got_cmds.size();
        repeat (30) @(negedge clk);
        check_eq("restart", "commands with start held", 32'(cmd_base), 32'(got_cmds.size()));
        check_eq("restart", "busy with start held", 32'd0, 32'(busy));
        byte_base = got_bytes.size();
        run_once(1'b0, cmd_base);
        check_sequence("restart", cmd_base, byte_base);
        end_test("restart", mark);

        $display("tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, errors, UUT.u_checker.assert_errors);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/i2c_cmd_port.sv ====
// registers the strobes toward the I2C master one clock after each pulse
// cmd and data strobes clear on their own ready
// cmd_start rides only on the first write after an address load
// a stop always goes out with cmd_start low
`timescale 1ns/100ps
`default_nettype none

module i2c_cmd_port (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          addr_load,
    input  wire i2c_init_pkg::i2c_addr_t addr,
    input  wire                          write_issue,
    input  wire [7:0]                    write_byte,
    input  wire                          stop_issue,
    input  wire                          cmd_ready,
    input  wire                          data_out_ready,
    output i2c_init_pkg::i2c_addr_t      cmd_address,
    output logic                         cmd_start,
    output logic                         cmd_write,
    output logic                         cmd_stop,
    output logic                         cmd_valid,
    output logic [7:0]                   data_out,
    output logic                         data_out_valid,
    output logic                         pending
);

    logic cmd_accept;
    logic data_accept;

    assign cmd_accept = cmd_valid & cmd_ready;
    assign data_accept = data_out_valid & data_out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_start <= 1'b0;
            cmd_write <= 1'b0;
            cmd_stop <= 1'b0;
            cmd_valid <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            // flags clear together with the accepted command
            if (cmd_accept) begin
                cmd_start <= 1'b0;
                cmd_write <= 1'b0;
                cmd_stop <= 1'b0;
                cmd_valid <= 1'b0;
            end
            if (data_accept) begin
                data_out_valid <= 1'b0;
            end
            // a new address arms start without raising valid
            if (addr_load) begin
                cmd_start <= 1'b1;
            end
            if (write_issue) begin
                cmd_write <= 1'b1;
                cmd_stop <= 1'b0;
                cmd_valid <= 1'b1;
                data_out_valid <= 1'b1;
            end
            if (stop_issue) begin
                cmd_start <= 1'b0;
                cmd_write <= 1'b0;
                cmd_stop <= 1'b1;
                cmd_valid <= 1'b1;
            end
        end
    end

    // payload only moves on a pulse so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (addr_load) begin
            cmd_address <= addr;
        end
        if (write_issue) begin
            data_out <= write_byte;
        end
    end

    assign pending = cmd_valid | data_out_valid;

endmodule

`default_nettype wire

// ==== hdl/i2c_init.sv ====
// power-on I2C init sequencer, top level
// cmd_read, cmd_write_multiple and data_out_last are tied off by the master
// busy rises two clocks after start, falls a clock after the final stop
`timescale 1ns/100ps
`default_nettype none

module i2c_init (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,
    input  wire                          cmd_ready,
    input  wire                          data_out_ready,
    output i2c_init_pkg::i2c_addr_t      cmd_address,
    output logic                         cmd_start,
    output logic                         cmd_write,
    output logic                         cmd_stop,
    output logic                         cmd_valid,
    output logic [7:0]                   data_out,
    output logic                         data_out_valid,
    output logic                         busy
);

    logic [i2c_init_pkg::table_aw-1:0] rom_addr;
    i2c_init_pkg::entry_t              entry;
    logic                              pending;
    // single-cycle pulses from sequencer to port
    logic                              addr_load;
    i2c_init_pkg::i2c_addr_t           addr;
    logic                              write_issue;
    logic [7:0]                        write_byte;
    logic                              stop_issue;

    init_table_rom u_rom (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .entry    (entry)
    );

    init_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .entry       (entry),
        .pending     (pending),
        .rom_addr    (rom_addr),
        .addr_load   (addr_load),
        .addr        (addr),
        .write_issue (write_issue),
        .write_byte  (write_byte),
        .stop_issue  (stop_issue),
        .busy        (busy)
    );

    i2c_cmd_port u_port (
        .clk            (clk),
        .rst            (rst),
        .addr_load      (addr_load),
        .addr           (addr),
        .write_issue    (write_issue),
        .write_byte     (write_byte),
        .stop_issue     (stop_issue),
        .cmd_ready      (cmd_ready),
        .data_out_ready (data_out_ready),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .pending        (pending)
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_init_pkg.sv ====
// shared types, opcodes and the init table for the I2C init sequencer
// the table is fixed at build time; editing it changes the command stream
// table_aw must cover table_len, so keep both in step when resizing
`default_nettype none

package i2c_init_pkg;

    localparam int table_len = 22;
    localparam int table_aw = $clog2(table_len);

    // bit 8 set means a data byte, 01 in [8:7] means a write address
    typedef logic [8:0] entry_t;
    typedef logic [6:0] i2c_addr_t;

    // control codes, top pair 00
    localparam entry_t op_stop       = 9'd0;
    localparam entry_t op_exit_multi = 9'd1;
    localparam entry_t op_write_cur  = 9'd3;
    localparam entry_t op_addr_block = 9'd8;
    localparam entry_t op_data_block = 9'd9;
    localparam entry_t op_send_stop  = 9'd65;

    typedef enum logic [2:0] {
        st_idle,
        st_run,
        st_find_addr_block,
        st_next_addr,
        st_replay
    } seq_state_t;

    localparam entry_t init_table [table_len] = '{
        // single device, reg 0x0004 <= 0x11223344 at 0x50
        {2'b01, 7'h50},
        {1'b1, 8'h00}, {1'b1, 8'h04},
        {1'b1, 8'h11}, {1'b1, 8'h22}, {1'b1, 8'h33}, {1'b1, 8'h44},
        // same write replayed for every address below
        op_data_block,
        op_write_cur,
        {1'b1, 8'h00}, {1'b1, 8'h04},
        {1'b1, 8'h11}, {1'b1, 8'h22}, {1'b1, 8'h33}, {1'b1, 8'h44},
        op_addr_block,
        {2'b01, 7'h50}, {2'b01, 7'h51}, {2'b01, 7'h52}, {2'b01, 7'h53},
        op_exit_multi,
        op_stop
    };

endpackage

`default_nettype wire

// ==== hdl/init_sequencer.sv ====
// walks the init table and emits one-cycle command pulses
// takes no step while the command port reports pending
// a run needs start low, then high, while idle
`timescale 1ns/100ps
`default_nettype none

module init_sequencer (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               start,
    input  wire i2c_init_pkg::entry_t         entry,
    input  wire                               pending,
    output logic [i2c_init_pkg::table_aw-1:0] rom_addr,
    output logic                              addr_load,
    output i2c_init_pkg::i2c_addr_t           addr,
    output logic                              write_issue,
    output logic [7:0]                        write_byte,
    output logic                              stop_issue,
    output logic                              busy
);

    i2c_init_pkg::seq_state_t state;
    i2c_init_pkg::seq_state_t state_next;

    // table pointer, entry holds the word at ptr
    logic [i2c_init_pkg::table_aw-1:0] ptr;
    logic [i2c_init_pkg::table_aw-1:0] ptr_next;
    // first entry after the data-block code
    logic [i2c_init_pkg::table_aw-1:0] data_ptr;
    logic [i2c_init_pkg::table_aw-1:0] data_ptr_next;
    // next address entry to use in the address block
    logic [i2c_init_pkg::table_aw-1:0] addr_ptr;
    logic [i2c_init_pkg::table_aw-1:0] addr_ptr_next;

    i2c_init_pkg::i2c_addr_t cur_addr;
    i2c_init_pkg::i2c_addr_t cur_addr_next;

    // start already seen high, cleared once start drops
    logic start_seen;
    logic start_seen_next;

    logic is_data;
    logic is_addr;

    assign is_data = entry[8];
    assign is_addr = (entry[8:7] == 2'b01);

    // ROM is addressed with the next pointer so entry lines up with ptr
    assign rom_addr = ptr_next;

    always_comb begin
        state_next = state;
        ptr_next = ptr;
        data_ptr_next = data_ptr;
        addr_ptr_next = addr_ptr;
        cur_addr_next = cur_addr;
        start_seen_next = start_seen;

        addr_load = 1'b0;
        addr = entry[6:0];
        write_issue = 1'b0;
        write_byte = entry[7:0];
        stop_issue = 1'b0;

        // hold everything until the master drains the port
        if (!pending) begin
            if (state == i2c_init_pkg::st_idle) begin
                if (!start_seen && start) begin
                    ptr_next = '0;
                    start_seen_next = 1'b1;
                    state_next = i2c_init_pkg::st_run;
                end
            end else if (entry == i2c_init_pkg::op_stop) begin
                // end of table, pointer left on the stop word
                stop_issue = 1'b1;
                state_next = i2c_init_pkg::st_idle;
            end else if (entry == i2c_init_pkg::op_data_block) begin
                // remember data start, then look for the addresses
                data_ptr_next = ptr + 1'b1;
                ptr_next = ptr + 1'b1;
                state_next = i2c_init_pkg::st_find_addr_block;
            end else if (entry == i2c_init_pkg::op_exit_multi) begin
                // harmless in run, acts as a skip there
                ptr_next = ptr + 1'b1;
                state_next = i2c_init_pkg::st_run;
            end else begin
                // default step is one entry forward, unknown codes just skip
                ptr_next = ptr + 1'b1;
                case (state)
                    i2c_init_pkg::st_run,
                    i2c_init_pkg::st_replay: begin
                        if (is_data) begin
                            write_issue = 1'b1;
                        end else if (is_addr) begin
                            addr_load = 1'b1;
                        end else if (entry == i2c_init_pkg::op_send_stop) begin
                            stop_issue = 1'b1;
                        end else if (state == i2c_init_pkg::st_replay &&
                                     entry == i2c_init_pkg::op_write_cur) begin
                            // address taken from the address block
                            addr_load = 1'b1;
                            addr = cur_addr;
                        end else if (state == i2c_init_pkg::st_replay &&
                                     entry == i2c_init_pkg::op_addr_block) begin
                            // data block done, back for the next address
                            ptr_next = addr_ptr;
                            state_next = i2c_init_pkg::st_next_addr;
                        end
                    end
                    i2c_init_pkg::st_find_addr_block: begin
                        // everything before the address block is passed over
                        if (entry == i2c_init_pkg::op_addr_block) begin
                            addr_ptr_next = ptr + 1'b1;
                            state_next = i2c_init_pkg::st_next_addr;
                        end
                    end
                    i2c_init_pkg::st_next_addr: begin
                        if (is_addr) begin
                            cur_addr_next = entry[6:0];
                            addr_ptr_next = ptr + 1'b1;
                            ptr_next = data_ptr;
                            state_next = i2c_init_pkg::st_replay;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= i2c_init_pkg::st_idle;
            ptr <= '0;
            data_ptr <= '0;
            addr_ptr <= '0;
            start_seen <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            ptr <= ptr_next;
            data_ptr <= data_ptr_next;
            addr_ptr <= addr_ptr_next;
            // re-arm as soon as start is low
            start_seen <= start & start_seen_next;
            // lags the state by one clock
            busy <= (state != i2c_init_pkg::st_idle);
        end
    end

    always_ff @(posedge clk) begin
        cur_addr <= cur_addr_next;
    end

endmodule

`default_nettype wire

// ==== hdl/init_table_rom.sv ====
// init table ROM with one clock of read latency
// pointers past the end of the table read back as a stop code
`timescale 1ns/100ps
`default_nettype none

module init_table_rom (
    input  wire                               clk,
    input  wire                               rst,
    input  wire [i2c_init_pkg::table_aw-1:0]  rom_addr,
    output i2c_init_pkg::entry_t              entry
);

    logic in_range;

    // 5-bit pointer spans 32 slots, table holds fewer
    assign in_range = int'(rom_addr) < i2c_init_pkg::table_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry <= '0;
        end else if (in_range) begin
            entry <= i2c_init_pkg::init_table[rom_addr];
        end else begin
            // out of range ends the run cleanly
            entry <= i2c_init_pkg::op_stop;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; passes only when the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_i2c_init -f sim.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && echo "result: pass" || { echo "result: fail"; exit 1; }

// ==== sim.f ====
hdl/i2c_init_pkg.sv
hdl/init_table_rom.sv
hdl/init_sequencer.sv
hdl/i2c_cmd_port.sv
hdl/i2c_init.sv
bench/i2c_init_checker.sv
bench/tb_i2c_init.sv
